/* common/pi1_pkg.sv */
// PI1 peripheral bus definitions
// Operation codes, bus widths, the request word and arbiter sizing

package pi1_pkg;

	localparam int ARCHBITSZ = 32; // Data word width
	localparam int SELBITSZ = ARCHBITSZ / 8; // One select bit per byte
	localparam int BYTEIDXBITSZ = $clog2(SELBITSZ);
	localparam int ADDRBITSZ = ARCHBITSZ - BYTEIDXBITSZ; // Word address

	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WR   = 2'b01,
		PI1_RD   = 2'b10,
		PI1_RW   = 2'b11 // Read old word, then write new one
	} pi1_op_t;

	// One PI1 request as driven by a master
	typedef struct packed {
		pi1_op_t                op;
		logic [ADDRBITSZ-1:0]   addr;
		logic [ARCHBITSZ-1:0]   data;
		logic [SELBITSZ-1:0]    sel;
	} pi1_req_t;

	localparam int PI1Q_MASTERS = 2;
	localparam int PI1Q_GRANTBITSZ = $clog2(PI1Q_MASTERS); // Owner register width

endpackage

/* common/axi4_pkg.sv */
// AXI4 memory port definitions
// Channel payload structs, fixed field values and RAM slave sizing

package axi4_pkg;

	localparam int AXI4_ID_WIDTH = 4;
	localparam int AXI4_ADDR_WIDTH = 32;
	localparam int AXI4_DATA_WIDTH = 32;
	localparam int AXI4_STRB_WIDTH = AXI4_DATA_WIDTH / 8;
	localparam int AXI4_LSB_BITS = $clog2(AXI4_STRB_WIDTH); // Byte index bits

	localparam logic [2:0] AXI4_SIZE_WORD = 3'b010; // 4 bytes per beat
	localparam logic [1:0] AXI4_BURST_INCR = 2'b01;
	localparam logic [1:0] AXI4_RESP_OKAY = 2'b00;

	// Write address channel, also used for read address
	typedef struct packed {
		logic [AXI4_ID_WIDTH-1:0]   id;
		logic [AXI4_ADDR_WIDTH-1:0] addr;
		logic [7:0]                 len;
		logic [2:0]                 size;
		logic [1:0]                 burst;
		logic [0:0]                 lock;
		logic [3:0]                 cache;
		logic [2:0]                 prot;
		logic [3:0]                 qos;
	} axi4_aw_t;

	typedef axi4_aw_t axi4_ar_t;

	typedef struct packed {
		logic [AXI4_DATA_WIDTH-1:0] data;
		logic [AXI4_STRB_WIDTH-1:0] strb;
		logic                       last;
	} axi4_w_t;

	typedef struct packed {
		logic [AXI4_ID_WIDTH-1:0] id;
		logic [1:0]               resp;
	} axi4_b_t;

	typedef struct packed {
		logic [AXI4_ID_WIDTH-1:0]   id;
		logic [AXI4_DATA_WIDTH-1:0] data;
		logic [1:0]                 resp;
		logic                       last;
	} axi4_r_t;

	localparam int RAM_WORDS = 64;
	localparam int RAM_IDX_BITS = $clog2(RAM_WORDS);
	localparam int RAM_LAT_BITS = 2;
	localparam logic [RAM_LAT_BITS-1:0] RAM_RD_LATENCY = 2; // AR accepted to RVALID

endpackage

/* hw/pi1q/pi1q.sv */
// Two-master PI1 arbiter
// The owner keeps the bus until it goes idle; responses return to the owner only
`timescale 1ns/1ps

module pi1q (
	input  logic                                axi4_clk_i,
	input  logic                                reset_i,

	input  pi1_pkg::pi1_req_t                   m_req_i [pi1_pkg::PI1Q_MASTERS],
	output logic [pi1_pkg::ARCHBITSZ-1:0]       m_data_o [pi1_pkg::PI1Q_MASTERS],
	output logic [pi1_pkg::PI1Q_MASTERS-1:0]    m_rdy_o,

	output pi1_pkg::pi1_req_t                   s_req_o,
	input  logic [pi1_pkg::ARCHBITSZ-1:0]       s_data_i,
	input  logic                                s_rdy_i
);

	logic [pi1_pkg::PI1Q_GRANTBITSZ-1:0] owner_q;
	logic [pi1_pkg::PI1Q_GRANTBITSZ-1:0] other;
	logic                                owner_idle;
	logic                                other_wants;

	assign other = owner_q + 1'b1; // Wraps to the next master
	assign owner_idle = (m_req_i[owner_q].op == pi1_pkg::PI1_NOOP);
	assign other_wants = (m_req_i[other].op != pi1_pkg::PI1_NOOP);

	// Ownership can move only once the owner's last response is out
	always_ff @(posedge axi4_clk_i) begin
		if (reset_i) begin
			owner_q <= '0;
		end else if (s_rdy_i && owner_idle && other_wants) begin
			owner_q <= other;
		end
	end

	assign s_req_o = m_req_i[owner_q];

	always_comb begin
		for (int i = 0; i < pi1_pkg::PI1Q_MASTERS; i++) begin
			m_rdy_o[i] = s_rdy_i && (owner_q == i[pi1_pkg::PI1Q_GRANTBITSZ-1:0]);
			m_data_o[i] = m_rdy_o[i] ? s_data_i : '0; // Idle masters see zero
		end
	end

	// A transaction in flight pins the owner
	owner_stable_a: assert property (
		@(posedge axi4_clk_i) disable iff (reset_i)
		!s_rdy_i |=> $stable(owner_q)
	);

endmodule

/* hw/pi1q_to_axi4/pi1q_to_axi4.sv */
// PI1 to AXI4 bridge issuing single-beat transactions
// Swap runs as a read followed by a write to the same address
`timescale 1ns/1ps

module pi1q_to_axi4 (
	input  logic                            axi4_clk_i,
	input  logic                            reset_i,

	input  pi1_pkg::pi1_req_t               s_req_i,
	output logic [pi1_pkg::ARCHBITSZ-1:0]   s_data_o,
	output logic                            s_rdy_o,

	output axi4_pkg::axi4_aw_t              aw_o,
	output logic                            awvalid_o,
	input  logic                            awready_i,

	output axi4_pkg::axi4_w_t               w_o,
	output logic                            wvalid_o,
	input  logic                            wready_i,

	input  axi4_pkg::axi4_b_t               b_i,
	input  logic                            bvalid_i,
	output logic                            bready_o,

	output axi4_pkg::axi4_ar_t              ar_o,
	output logic                            arvalid_o,
	input  logic                            arready_i,

	input  axi4_pkg::axi4_r_t               r_i,
	input  logic                            rvalid_i,
	output logic                            rready_o
);

	logic cyc; // Transaction in flight
	logic we; // Current phase waits on B, else on R
	logic wrpending; // Swap still has its write to do
	logic awvalid_q, wvalid_q, arvalid_q;
	logic bready_q, rready_q;
	logic ack, answer;

	pi1_pkg::pi1_op_t                      op_hold;
	logic [axi4_pkg::AXI4_ADDR_WIDTH-1:0]  axaddr_q;
	logic [axi4_pkg::AXI4_DATA_WIDTH-1:0]  wdata_q;
	logic [axi4_pkg::AXI4_STRB_WIDTH-1:0]  wstrb_q;
	logic [pi1_pkg::ARCHBITSZ-1:0]         rdata_hold;
	logic [pi1_pkg::BYTEIDXBITSZ-1:0]      byte_idx;

	// Byte address points at the lowest selected byte
	always_comb begin
		byte_idx = '0;
		for (int i = pi1_pkg::SELBITSZ - 1; i >= 0; i--) begin
			if (s_req_i.sel[i])
				byte_idx = i[pi1_pkg::BYTEIDXBITSZ-1:0];
		end
	end

	assign ack = cyc && (we ? (bvalid_i && bready_q) : (rvalid_i && rready_q));
	assign s_rdy_o = !reset_i && (!cyc || (ack && !wrpending));
	assign answer = s_rdy_o && cyc;

	always_comb begin
		s_data_o = '0;
		if (answer && op_hold == pi1_pkg::PI1_RW)
			s_data_o = rdata_hold; // Old word from the read phase
		else if (answer && op_hold == pi1_pkg::PI1_RD)
			s_data_o = r_i.data;
	end

	always_ff @(posedge axi4_clk_i) begin
		if (reset_i) begin
			cyc <= 1'b0;
			we <= 1'b0;
			wrpending <= 1'b0;
			awvalid_q <= 1'b0;
			wvalid_q <= 1'b0;
			arvalid_q <= 1'b0;
			bready_q <= 1'b0;
			rready_q <= 1'b0;
		end else begin
			if (awready_i)
				awvalid_q <= 1'b0;
			if (wready_i)
				wvalid_q <= 1'b0;
			if (arready_i)
				arvalid_q <= 1'b0;
			if (s_rdy_o) begin
				cyc <= 1'b0;
				we <= 1'b0;
				wrpending <= 1'b0;
				bready_q <= 1'b0;
				rready_q <= 1'b0;
				case (s_req_i.op)
					pi1_pkg::PI1_WR: begin
						cyc <= 1'b1;
						we <= 1'b1;
						awvalid_q <= 1'b1;
						wvalid_q <= 1'b1;
						bready_q <= 1'b1;
					end
					pi1_pkg::PI1_RD, pi1_pkg::PI1_RW: begin
						cyc <= 1'b1;
						wrpending <= (s_req_i.op == pi1_pkg::PI1_RW);
						arvalid_q <= 1'b1;
						rready_q <= 1'b1;
					end
					default: ;
				endcase
			end else if (wrpending && ack) begin
				we <= 1'b1; // Swap turns into its write phase
				wrpending <= 1'b0;
				rready_q <= 1'b0;
				awvalid_q <= 1'b1;
				wvalid_q <= 1'b1;
				bready_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge axi4_clk_i) begin
		if (s_rdy_o) begin
			op_hold <= s_req_i.op;
			axaddr_q <= {s_req_i.addr, byte_idx};
			wdata_q <= s_req_i.data;
			wstrb_q <= s_req_i.sel;
		end
		if (wrpending && ack)
			rdata_hold <= r_i.data;
	end

	assign aw_o = '{id: '0, addr: axaddr_q, len: 8'd0, size: axi4_pkg::AXI4_SIZE_WORD,
		burst: axi4_pkg::AXI4_BURST_INCR, lock: 1'b0, cache: 4'b0000, prot: 3'b000,
		qos: 4'b0000};
	assign ar_o = aw_o; // Same address and fixed fields
	assign w_o = '{data: wdata_q, strb: wstrb_q, last: 1'b1};

	assign awvalid_o = awvalid_q;
	assign wvalid_o = wvalid_q;
	assign arvalid_o = arvalid_q;
	assign bready_o = bready_q;
	assign rready_o = rready_q;

	// VALID held until the slave takes it
	aw_hold_a: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
		awvalid_o && !awready_i |=> awvalid_o);
	w_hold_a: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
		wvalid_o && !wready_i |=> wvalid_o);
	ar_hold_a: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
		arvalid_o && !arready_i |=> arvalid_o);

	rd_wr_excl_a: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
		!((arvalid_o || rready_o) && (awvalid_o || wvalid_o || bready_o)));

	// Slave echoes the request ID
	bid_echo_a: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
		bvalid_i && bready_o |-> b_i.id == aw_o.id);

endmodule

/* hw/axi4_ram.sv */
// AXI4 single-beat RAM slave
// Fixed read latency, byte strobes on writes, words wrap at the RAM depth
`timescale 1ns/1ps

module axi4_ram (
	input  logic                axi4_clk_i,
	input  logic                reset_i,

	input  axi4_pkg::axi4_aw_t  aw_i,
	input  logic                awvalid_i,
	output logic                awready_o,

	input  axi4_pkg::axi4_w_t   w_i,
	input  logic                wvalid_i,
	output logic                wready_o,

	output axi4_pkg::axi4_b_t   b_o,
	output logic                bvalid_o,
	input  logic                bready_i,

	input  axi4_pkg::axi4_ar_t  ar_i,
	input  logic                arvalid_i,
	output logic                arready_o,

	output axi4_pkg::axi4_r_t   r_o,
	output logic                rvalid_o,
	input  logic                rready_i
);

	localparam int LSB = axi4_pkg::AXI4_LSB_BITS;
	localparam int IDXB = axi4_pkg::RAM_IDX_BITS;

	logic [axi4_pkg::AXI4_DATA_WIDTH-1:0] mem [axi4_pkg::RAM_WORDS];

	logic aw_done, w_done, bvalid_q;
	logic rd_busy, rvalid_q;
	logic aw_fire, w_fire, ar_fire, aw_have, w_have;
	logic [axi4_pkg::RAM_LAT_BITS-1:0] rd_cnt;

	logic [axi4_pkg::AXI4_ADDR_WIDTH-1:0] awaddr_q, wr_addr;
	logic [axi4_pkg::AXI4_DATA_WIDTH-1:0] wdata_q, wr_data, rdata_q;
	logic [axi4_pkg::AXI4_STRB_WIDTH-1:0] wstrb_q, wr_strb;
	logic [axi4_pkg::AXI4_ID_WIDTH-1:0]   bid_q, rid_q;
	logic [IDXB-1:0]                      rd_idx;

	assign awready_o = !aw_done && !bvalid_q;
	assign wready_o = !w_done && !bvalid_q;
	assign arready_o = !rd_busy;
	assign aw_fire = awvalid_i && awready_o;
	assign w_fire = wvalid_i && wready_o;
	assign ar_fire = arvalid_i && arready_o;
	assign aw_have = aw_done || aw_fire;
	assign w_have = w_done || w_fire;

	// Take this cycle's beat or the one latched earlier
	assign wr_addr = aw_done ? awaddr_q : aw_i.addr;
	assign wr_data = w_done ? wdata_q : w_i.data;
	assign wr_strb = w_done ? wstrb_q : w_i.strb;

	always_ff @(posedge axi4_clk_i) begin
		if (reset_i) begin
			aw_done <= 1'b0;
			w_done <= 1'b0;
			bvalid_q <= 1'b0;
			rd_busy <= 1'b0;
			rvalid_q <= 1'b0;
			for (int i = 0; i < axi4_pkg::RAM_WORDS; i++)
				mem[i] <= '0;
		end else begin
			if (aw_have && w_have) begin
				for (int b = 0; b < axi4_pkg::AXI4_STRB_WIDTH; b++) begin
					if (wr_strb[b])
						mem[wr_addr[LSB +: IDXB]][8*b +: 8] <= wr_data[8*b +: 8];
				end
				aw_done <= 1'b0;
				w_done <= 1'b0;
				bvalid_q <= 1'b1;
			end else begin
				aw_done <= aw_have;
				w_done <= w_have;
			end
			if (bvalid_q && bready_i)
				bvalid_q <= 1'b0;

			if (ar_fire) begin
				rd_busy <= 1'b1;
				rd_cnt <= '0;
			end else if (rd_busy && !rvalid_q) begin
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt + 1'b1 == axi4_pkg::RAM_RD_LATENCY) begin
					rvalid_q <= 1'b1;
					rdata_q <= mem[rd_idx];
				end
			end else if (rvalid_q && rready_i) begin
				rvalid_q <= 1'b0;
				rd_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge axi4_clk_i) begin
		if (aw_fire) begin
			awaddr_q <= aw_i.addr;
			bid_q <= aw_i.id;
		end
		if (w_fire) begin
			wdata_q <= w_i.data;
			wstrb_q <= w_i.strb;
		end
		if (ar_fire) begin
			rd_idx <= ar_i.addr[LSB +: IDXB];
			rid_q <= ar_i.id;
		end
	end

	assign bvalid_o = bvalid_q;
	assign b_o = '{id: bid_q, resp: axi4_pkg::AXI4_RESP_OKAY};
	assign rvalid_o = rvalid_q;
	assign r_o = '{id: rid_q, data: rdata_q, resp: axi4_pkg::AXI4_RESP_OKAY, last: 1'b1};

	// Every read response traces back to an AR accepted the set latency earlier
	r_after_ar_a: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
		$rose(rvalid_o) |-> $past(arvalid_i && arready_o, axi4_pkg::RAM_RD_LATENCY + 1));

endmodule

/* hw/pi1_axi4_sys.sv */
// PI1 to AXI4 subsystem top level
// Two PI1 masters share one bridge through the arbiter, backed by an AXI4 RAM
`timescale 1ns/1ps

module pi1_axi4_sys (
	input  logic                            axi4_clk_i,
	input  logic                            reset_i,

	input  pi1_pkg::pi1_req_t               m0_req_i,
	output logic [pi1_pkg::ARCHBITSZ-1:0]   m0_data_o,
	output logic                            m0_rdy_o,

	input  pi1_pkg::pi1_req_t               m1_req_i,
	output logic [pi1_pkg::ARCHBITSZ-1:0]   m1_data_o,
	output logic                            m1_rdy_o
);

	pi1_pkg::pi1_req_t                     m_req [pi1_pkg::PI1Q_MASTERS];
	logic [pi1_pkg::ARCHBITSZ-1:0]         m_data [pi1_pkg::PI1Q_MASTERS];
	logic [pi1_pkg::PI1Q_MASTERS-1:0]      m_rdy;

	pi1_pkg::pi1_req_t                     s_req;
	logic [pi1_pkg::ARCHBITSZ-1:0]         s_data;
	logic                                  s_rdy;

	axi4_pkg::axi4_aw_t aw;
	axi4_pkg::axi4_w_t  w;
	axi4_pkg::axi4_b_t  b;
	axi4_pkg::axi4_ar_t ar;
	axi4_pkg::axi4_r_t  r;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;

	assign m_req[0] = m0_req_i;
	assign m_req[1] = m1_req_i;
	assign m0_data_o = m_data[0];
	assign m1_data_o = m_data[1];
	assign m0_rdy_o = m_rdy[0];
	assign m1_rdy_o = m_rdy[1];

	pi1q pi1q_inst (
		.axi4_clk_i (axi4_clk_i), .reset_i (reset_i),
		.m_req_i (m_req), .m_data_o (m_data), .m_rdy_o (m_rdy),
		.s_req_o (s_req), .s_data_i (s_data), .s_rdy_i (s_rdy)
	);

	pi1q_to_axi4 pi1q_to_axi4_inst (
		.axi4_clk_i (axi4_clk_i), .reset_i (reset_i),
		.s_req_i (s_req), .s_data_o (s_data), .s_rdy_o (s_rdy),
		.aw_o (aw), .awvalid_o (awvalid), .awready_i (awready),
		.w_o (w), .wvalid_o (wvalid), .wready_i (wready),
		.b_i (b), .bvalid_i (bvalid), .bready_o (bready),
		.ar_o (ar), .arvalid_o (arvalid), .arready_i (arready),
		.r_i (r), .rvalid_i (rvalid), .rready_o (rready)
	);

	axi4_ram axi4_ram_inst (
		.axi4_clk_i (axi4_clk_i), .reset_i (reset_i),
		.aw_i (aw), .awvalid_i (awvalid), .awready_o (awready),
		.w_i (w), .wvalid_i (wvalid), .wready_o (wready),
		.b_o (b), .bvalid_o (bvalid), .bready_i (bready),
		.ar_i (ar), .arvalid_i (arvalid), .arready_o (arready),
		.r_o (r), .rvalid_o (rvalid), .rready_i (rready)
	);

endmodule

/* sim/pi1_checker.sv */
// PI1 response checker
// Captures each master's response data and flags bus ownership violations
`timescale 1ns/1ps

module pi1_checker (
	input  logic                            axi4_clk_i,
	input  logic                            reset_i,
	input  pi1_pkg::pi1_req_t               m0_req_i,
	input  logic [pi1_pkg::ARCHBITSZ-1:0]   m0_data_i,
	input  logic                            m0_rdy_i,
	input  pi1_pkg::pi1_req_t               m1_req_i,
	input  logic [pi1_pkg::ARCHBITSZ-1:0]   m1_data_i,
	input  logic                            m1_rdy_i
);

	int error_count = 0;
	int timeout_count = 0;

	bit [1:0] busy = '0; // Master has an accepted request in flight
	logic [1:0] rdy;
	logic [pi1_pkg::ARCHBITSZ-1:0] data [2];
	logic [pi1_pkg::ARCHBITSZ-1:0] resp_data [2];
	pi1_pkg::pi1_op_t op [2];

	assign rdy = {m1_rdy_i, m0_rdy_i};
	assign data[0] = m0_data_i;
	assign data[1] = m1_data_i;
	assign op[0] = m0_req_i.op;
	assign op[1] = m1_req_i.op;

	// Outputs only change on the rising edge, so the falling edge sees them settled
	always @(negedge axi4_clk_i) begin
		if (reset_i) begin
			busy = '0;
			if (rdy != 2'b00) begin
				error_count++;
				$display("A master's rdy is high while reset is asserted");
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (busy[i] && rdy[1-i]) begin
					error_count++;
					$display("Bus conflict: m%0d rdy is high while m%0d owns the bus", 1 - i, i);
				end
				if (!rdy[i] && data[i] != '0) begin
					error_count++;
					$display("m%0d drives nonzero read data while its rdy is low", i);
				end
				if (rdy[i]) begin
					if (busy[i])
						resp_data[i] = data[i]; // Response cycle
					busy[i] = (op[i] != pi1_pkg::PI1_NOOP);
				end
			end
		end
	end

	task automatic check_read(input int m, input string name,
		input logic [pi1_pkg::ARCHBITSZ-1:0] exp);
		if (resp_data[m] !== exp) begin
			error_count++;
			$display("ERROR %s: expected %08h, actual %08h", name, exp, resp_data[m]);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			error_count++;
			$display("ERROR %s: expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic note_timeout(input string name, input int m, input int limit);
		timeout_count++;
		$display("Timeout in %s: m%0d rdy did not rise within %0d cycles", name, m, limit);
	endtask

	task automatic note_error(input string msg);
		error_count++;
		$display("%s", msg);
	endtask

endmodule

/* sim/pi1_axi4_sys_tb.sv */
// Testbench for the PI1 to AXI4 subsystem
// Replays bus transactions from a vector file on two PI1 masters
`timescale 1ns/1ps

module pi1_axi4_sys_tb;

	localparam int WAIT_LIMIT = 100; // Cycles allowed per wait

	logic axi4_clk_i;
	logic reset_i;
	pi1_pkg::pi1_req_t req [2];
	logic [pi1_pkg::ARCHBITSZ-1:0] m0_data, m1_data;
	logic m0_rdy, m1_rdy;
	logic [1:0] rdy;

	// Vectors in file order
	string vec_name [$];
	int vec_master [$];
	pi1_pkg::pi1_req_t vec_req [$];
	logic [31:0] vec_exp [$];
	int vec_chk [$];

	assign rdy = {m1_rdy, m0_rdy};

	always #4 axi4_clk_i = ~axi4_clk_i;

	pi1_axi4_sys pi1_axi4_sys_inst (
		.axi4_clk_i (axi4_clk_i), .reset_i (reset_i),
		.m0_req_i (req[0]), .m0_data_o (m0_data), .m0_rdy_o (m0_rdy),
		.m1_req_i (req[1]), .m1_data_o (m1_data), .m1_rdy_o (m1_rdy)
	);

	pi1_checker pi1_checker_inst (
		.axi4_clk_i (axi4_clk_i), .reset_i (reset_i),
		.m0_req_i (req[0]), .m0_data_i (m0_data), .m0_rdy_i (m0_rdy),
		.m1_req_i (req[1]), .m1_data_i (m1_data), .m1_rdy_i (m1_rdy)
	);

	task automatic wait_rdy(input int m, input string name, output bit ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(negedge axi4_clk_i);
			ok = rdy[m];
			cycles++;
		end
		if (!ok)
			pi1_checker_inst.note_timeout(name, m, WAIT_LIMIT);
	endtask

	// Hold the presented request until accepted, then NOOP until the response cycle
	task automatic run_vector(input int m, input string name, output bit ok);
		wait_rdy(m, name, ok);
		if (ok) begin
			@(posedge axi4_clk_i);
			req[m] <= '0; // All-zero request is a NOOP
			wait_rdy(m, name, ok);
			@(posedge axi4_clk_i);
		end
	endtask

	initial begin
		int fd, n, m, op, chk;
		string line, name;
		logic [31:0] addr, data, sel, exp;
		pi1_pkg::pi1_req_t r;
		bit ok, early;

		axi4_clk_i = 1'b0;
		reset_i = 1'b1;
		req[0] = '0;
		req[1] = '0;
		ok = 1'b1;
		early = 1'b0;
		repeat (2) @(posedge axi4_clk_i);
		reset_i <= 1'b0;
		@(negedge axi4_clk_i);
		pi1_checker_inst.check_value("rdy_after_reset", 32'd1, {31'd0, m0_rdy});

		fd = $fopen("sim/pi1_vectors.txt", "r");
		if (fd == 0)
			pi1_checker_inst.note_error("Could not open the vector file sim/pi1_vectors.txt");
		while (fd != 0 && !$feof(fd)) begin
			if ($fgets(line, fd) == 0 || line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %d %d %h %h %h %h %d",
				name, m, op, addr, data, sel, exp, chk);
			if (n != 8 || m < 0 || m > 1) begin
				pi1_checker_inst.note_error({"Malformed vector line: ", line});
				continue;
			end
			r.op = pi1_pkg::pi1_op_t'(op[1:0]);
			r.addr = addr[pi1_pkg::ADDRBITSZ-1:0];
			r.data = data;
			r.sel = sel[pi1_pkg::SELBITSZ-1:0];
			vec_name.push_back(name);
			vec_master.push_back(m);
			vec_req.push_back(r);
			vec_exp.push_back(exp);
			vec_chk.push_back(chk);
		end
		if (fd != 0)
			$fclose(fd);
		if (vec_name.size() == 0)
			pi1_checker_inst.note_error("No vectors were read");

		for (int i = 0; i < vec_name.size() && ok; i++) begin
			if (!early) begin
				@(posedge axi4_clk_i);
				req[vec_master[i]] <= vec_req[i];
			end
			// The other master's next request waits on the bus while this one runs
			early = (i + 1 < vec_name.size()) && (vec_master[i + 1] != vec_master[i]);
			if (early)
				req[vec_master[i + 1]] <= vec_req[i + 1];
			run_vector(vec_master[i], vec_name[i], ok);
			if (ok && vec_chk[i] != 0)
				pi1_checker_inst.check_read(vec_master[i], vec_name[i], vec_exp[i]);
		end

		$display("Errors: %0d, timeouts: %0d",
			pi1_checker_inst.error_count, pi1_checker_inst.timeout_count);
		if (pi1_checker_inst.error_count == 0 && pi1_checker_inst.timeout_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* sim/pi1_vectors.txt */
# name master op(1=write 2=read 3=swap) word_addr data sel expected check_read
# word_addr, data, sel and expected are hex; memory is all zero after reset
rd_unwritten   0 2 00000005 00000000 f 00000000 1
wr_full_a      0 1 00000005 deadbeef f 00000000 0
rd_full_a      0 2 00000005 00000000 f deadbeef 1
wr_full_b      0 1 00000006 12345678 f 00000000 0
rd_full_b      0 2 00000006 00000000 f 12345678 1
rd_a_kept      0 2 00000005 00000000 f deadbeef 1
wr_wrap        0 1 00000045 cafef00d f 00000000 0
rd_wrap_alias  0 2 00000005 00000000 f cafef00d 1
rd_b_after_wr  0 2 00000006 00000000 f 12345678 1
wr_partial     0 1 00000006 aabbccdd 6 00000000 0
rd_partial     0 2 00000006 00000000 f 12bbcc78 1
wr_full_c      0 1 00000007 11223344 f 00000000 0
swap_c         0 3 00000007 a5a5a5a5 c 11223344 1
rd_after_swap  0 2 00000007 00000000 f a5a53344 1
m1_rd_wrap     1 2 00000005 00000000 f cafef00d 1
m1_wr_d        1 1 00000008 0badcafe f 00000000 0
m0_rd_d        0 2 00000008 00000000 f 0badcafe 1
m1_swap_d      1 3 00000008 55555555 1 0badcafe 1
m0_rd_swapped  0 2 00000008 00000000 f 0badca55 1
m1_rd_partial  1 2 00000006 00000000 f 12bbcc78 1
m0_rd_c        0 2 00000007 00000000 f a5a53344 1

/* sources.f */
common/pi1_pkg.sv
common/axi4_pkg.sv
hw/pi1q/pi1q.sv
hw/pi1q_to_axi4/pi1q_to_axi4.sv
hw/axi4_ram.sv
hw/pi1_axi4_sys.sv
sim/pi1_checker.sv
sim/pi1_axi4_sys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PI1 to AXI4 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module pi1_axi4_sys_tb -f sources.f \
	--Mdir build -o pi1_axi4_sys_tb

./build/pi1_axi4_sys_tb | tee sim.log

# Exit status follows the search for the pass message
grep -q "all tests passed" sim.log
